// File: Bender.yml
package:
  name: c3sram

sources:
  - hdl/c3sram_pkg.sv
  - hdl/c3sram_apb_regs.sv
  - hdl/c3sram_row_sequencer.sv
  - hdl/c3sram_array_model.sv
  - hdl/c3sram_sense_latch.sv
  - hdl/c3sram_top.sv
  - target: test
    files:
      - tests/tb_c3sram_top.sv

// File: build.f
hdl/c3sram_pkg.sv
hdl/c3sram_apb_regs.sv
hdl/c3sram_row_sequencer.sv
hdl/c3sram_array_model.sv
hdl/c3sram_sense_latch.sv
hdl/c3sram_top.sv
tests/tb_c3sram_top.sv

// File: hdl/c3sram_apb_regs.sv
// APB register block for the row controller, with address, data and command registers.
// Accepted CMD writes become one-cycle pulses towards the row sequencer.
`default_nettype none

module c3sram_apb_regs #(
    parameter int NUM_ROWS = 128,
    parameter int NUM_COLS = 32
) (
    input  wire                         clk,
    input  wire                         nrst,
    input  wire c3sram_pkg::apb_req_t   apb_req_i,
    output c3sram_pkg::apb_rsp_t        apb_rsp_o,
    input  wire                         ready_i,
    input  wire [NUM_COLS-1:0]          rd_result_i,
    output logic                        cmd_write_o,
    output logic                        cmd_read_o,
    output logic [$clog2(NUM_ROWS)-1:0] row_addr_o,
    output logic [NUM_COLS-1:0]         wr_data_o
);

    localparam int ROW_W = $clog2(NUM_ROWS);

    logic                  access;
    logic                  wr_access;
    logic                  hit_addr;
    logic                  hit_wdata;
    logic                  hit_cmd;
    logic                  hit_status;
    logic                  hit_rdata;
    logic                  mapped;
    logic [1:0]            cmd_bits;
    logic                  cmd_idle;
    logic                  cmd_legal;
    logic                  slv_err;
    logic [ROW_W-1:0]      addr_q;
    logic [NUM_COLS-1:0]   wdata_q;
    logic                  cmd_write_q;
    logic                  cmd_read_q;
    c3sram_pkg::apb_data_t rdata_mux;

    assign access    = apb_req_i.psel & apb_req_i.penable;
    assign wr_access = access & apb_req_i.pwrite;

    // Offset decode
    assign hit_addr   = (apb_req_i.paddr == c3sram_pkg::REG_ADDR);
    assign hit_wdata  = (apb_req_i.paddr == c3sram_pkg::REG_WDATA);
    assign hit_cmd    = (apb_req_i.paddr == c3sram_pkg::REG_CMD);
    assign hit_status = (apb_req_i.paddr == c3sram_pkg::REG_STATUS);
    assign hit_rdata  = (apb_req_i.paddr == c3sram_pkg::REG_RDATA);
    assign mapped     = hit_addr | hit_wdata | hit_cmd | hit_status | hit_rdata;

    // A pulse still on its way counts as busy, the sequencer has not seen it yet
    assign cmd_bits  = apb_req_i.pwdata[1:0];
    assign cmd_idle  = ready_i & ~cmd_write_q & ~cmd_read_q;
    assign cmd_legal = cmd_idle & ((cmd_bits == 2'b01) | (cmd_bits == 2'b10));

    assign slv_err = access & (~mapped
                               | (apb_req_i.pwrite & (hit_status | hit_rdata))
                               | (wr_access & hit_cmd & ~cmd_legal));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            addr_q  <= '0;
            wdata_q <= '0;
        end else if (wr_access && !slv_err) begin
            if (hit_addr) begin
                addr_q <= apb_req_i.pwdata[ROW_W-1:0];
            end
            if (hit_wdata) begin
                wdata_q <= apb_req_i.pwdata[NUM_COLS-1:0];
            end
        end
    end

    // Command pulses, high for the cycle after the accepting edge
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd_write_q <= 1'b0;
            cmd_read_q  <= 1'b0;
        end else begin
            cmd_write_q <= wr_access & hit_cmd & cmd_legal & cmd_bits[0];
            cmd_read_q  <= wr_access & hit_cmd & cmd_legal & cmd_bits[1];
        end
    end

    // Read-back, zero-extended to the bus width
    always_comb begin
        rdata_mux = '0;
        if (hit_addr) begin
            rdata_mux = c3sram_pkg::apb_data_t'(addr_q);
        end else if (hit_wdata) begin
            rdata_mux = c3sram_pkg::apb_data_t'(wdata_q);
        end else if (hit_cmd) begin
            rdata_mux = c3sram_pkg::apb_data_t'({cmd_read_q, cmd_write_q});
        end else if (hit_status) begin
            rdata_mux = c3sram_pkg::apb_data_t'(cmd_idle);
        end else if (hit_rdata) begin
            rdata_mux = c3sram_pkg::apb_data_t'(rd_result_i);
        end
    end

    assign apb_rsp_o   = '{prdata: rdata_mux, pslverr: slv_err};
    assign cmd_write_o = cmd_write_q;
    assign cmd_read_o  = cmd_read_q;
    assign row_addr_o  = addr_q;
    assign wr_data_o   = wdata_q;

    a_cmd_exclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(cmd_write_o && cmd_read_o))
        else $error("write and read command pulses high together");

endmodule

`default_nettype wire

// File: hdl/c3sram_array_model.sv
// Behavioral C3SRAM bitcell array standing in for the macro in simulation.
// Writes and senses one row per wordline pulse.
`default_nettype none

module c3sram_array_model #(
    parameter int NUM_ROWS = 128,
    parameter int NUM_COLS = 32
) (
    input  wire                          clk,
    input  wire c3sram_pkg::array_ctrl_t ctrl_i,
    input  wire [NUM_ROWS-1:0]           wl_i,
    input  wire [NUM_COLS-1:0]           bl_data_i,
    output logic [NUM_COLS-1:0]          sa_out_o
);

    logic [NUM_COLS-1:0] mem [NUM_ROWS];
    logic [NUM_COLS-1:0] row_data;

    // Bitcells come up cleared in this model
    initial begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            mem[r] = '0;
        end
    end

    // Bitline drivers write every open row
    always @(posedge clk) begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (ctrl_i.w2b && wl_i[r]) begin
                mem[r] <= bl_data_i;
            end
        end
    end

    // Open row onto the bitlines
    always_comb begin
        row_data = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (wl_i[r]) begin
                row_data = row_data | mem[r];
            end
        end
    end

    // Sense amp output is only meaningful while enabled
    assign sa_out_o = ctrl_i.saen ? row_data : '0;

    a_saen_w2b_excl: assert property (@(posedge clk)
        !(ctrl_i.saen && ctrl_i.w2b))
        else $error("saen and w2b high together");

    a_saen_needs_wl: assert property (@(posedge clk)
        ctrl_i.saen |-> (|wl_i))
        else $error("sensing with no wordline open");

endmodule

`default_nettype wire

// File: hdl/c3sram_pkg.sv
// Shared types and register map for the C3SRAM row controller subsystem.
// RTL and testbench refer to these by scoped name.
`default_nettype none

package c3sram_pkg;

    // APB bus widths
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Host to slave, 47 bits
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // Slave to host, 33 bits
    typedef struct packed {
        apb_data_t prdata;
        logic      pslverr;
    } apb_rsp_t;

    // Array control pins besides the wordline bus
    typedef struct packed {
        logic saen;
        logic w2b;
        logic nprecharge;
    } array_ctrl_t;

    // Register offsets
    localparam apb_addr_t REG_ADDR   = 12'h000;
    localparam apb_addr_t REG_WDATA  = 12'h004;
    // Bit 0 write, bit 1 read
    localparam apb_addr_t REG_CMD    = 12'h008;
    // Bit 0 ready
    localparam apb_addr_t REG_STATUS = 12'h00C;
    localparam apb_addr_t REG_RDATA  = 12'h010;

endpackage

`default_nettype wire

// File: hdl/c3sram_row_sequencer.sv
// Row sequencer for the C3SRAM array, plays the fixed four-cycle write or read
// waveform on the array pins after a command pulse from the register block.
`default_nettype none

module c3sram_row_sequencer #(
    parameter int NUM_ROWS = 128,
    parameter int NUM_COLS = 32
) (
    input  wire                          clk,
    input  wire                          nrst,
    input  wire                          cmd_write_i,
    input  wire                          cmd_read_i,
    input  wire [$clog2(NUM_ROWS)-1:0]   row_addr_i,
    input  wire [NUM_COLS-1:0]           wr_data_i,
    output logic                         ready_o,
    output c3sram_pkg::array_ctrl_t      ctrl_o,
    output logic [NUM_ROWS-1:0]          wl_o,
    output logic [NUM_COLS-1:0]          bl_data_o
);

    localparam int ROW_W = $clog2(NUM_ROWS);

    // Waveforms indexed by position, position 3 is the first cycle
    localparam logic [3:0] W2B_WR   = 4'b1111;
    localparam logic [3:0] NPRE_WR  = 4'b1111;
    localparam logic [3:0] SAEN_RD  = 4'b0010;
    localparam logic [3:0] NPRE_RD  = 4'b1110;
    // Wordline pulse, the same for write and read
    localparam logic [3:0] WL_PULSE = 4'b0110;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITING,
        ST_READING
    } seq_state_e;

    seq_state_e          state_q;
    seq_state_e          state_d;
    logic [1:0]          pos_q;
    logic [ROW_W-1:0]    row_q;
    logic [NUM_COLS-1:0] data_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cmd_write_i) begin
                    state_d = ST_WRITING;
                end else if (cmd_read_i) begin
                    state_d = ST_READING;
                end
            end
            ST_WRITING, ST_READING: begin
                if (pos_q == 2'd0) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // Position counter, parked at 3 while idle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pos_q <= 2'd3;
        end else if (state_q == ST_IDLE) begin
            pos_q <= 2'd3;
        end else begin
            pos_q <= pos_q - 2'd1;
        end
    end

    // Target row and data, captured with the command
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && (cmd_write_i || cmd_read_i)) begin
            row_q  <= row_addr_i;
            data_q <= wr_data_i;
        end
    end

    always_comb begin
        ctrl_o    = '0;
        wl_o      = '0;
        bl_data_o = '0;
        case (state_q)
            ST_WRITING: begin
                ctrl_o.w2b        = W2B_WR[pos_q];
                ctrl_o.nprecharge = NPRE_WR[pos_q];
                bl_data_o         = data_q;
            end
            ST_READING: begin
                ctrl_o.saen       = SAEN_RD[pos_q];
                ctrl_o.nprecharge = NPRE_RD[pos_q];
            end
            default: ;
        endcase
        if (state_q != ST_IDLE) begin
            wl_o[row_q] = WL_PULSE[pos_q];
        end
    end

    assign ready_o = (state_q == ST_IDLE);

    a_no_cmd_busy: assert property (@(posedge clk) disable iff (!nrst)
        (cmd_write_i || cmd_read_i) |-> (state_q == ST_IDLE))
        else $error("command pulse while sequencer busy");

    a_wl_onehot: assert property (@(posedge clk) disable iff (!nrst)
        $onehot0(wl_o))
        else $error("more than one wordline high");

endmodule

`default_nettype wire

// File: hdl/c3sram_sense_latch.sv
// Result stage for reads, holds the sensed row until the next sense pulse.
`default_nettype none

module c3sram_sense_latch #(
    parameter int NUM_COLS = 32
) (
    input  wire                 clk,
    input  wire                 nrst,
    input  wire                 saen_i,
    input  wire [NUM_COLS-1:0]  sa_out_i,
    output logic [NUM_COLS-1:0] rd_result_o
);

    logic [NUM_COLS-1:0] result_q;

    // Loads on the saen edge and holds otherwise
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            result_q <= '0;
        end else if (saen_i) begin
            result_q <= sa_out_i;
        end
    end

    assign rd_result_o = result_q;

    // One sense per read, saen is a single-cycle pulse
    a_saen_pulse: assert property (@(posedge clk) disable iff (!nrst)
        saen_i |=> !saen_i)
        else $error("saen high for two cycles");

endmodule

`default_nettype wire

// File: hdl/c3sram_top.sv
// Memory subsystem top, APB register block driving the row sequencer, array model
// and sense latch. Sets the array geometry for all blocks.
`default_nettype none

module c3sram_top #(
    parameter int NUM_ROWS = 128,
    parameter int NUM_COLS = 32
) (
    input  wire                        clk,
    input  wire                        nrst,
    input  wire c3sram_pkg::apb_req_t  apb_req_i,
    output c3sram_pkg::apb_rsp_t       apb_rsp_o
);

    localparam int ROW_W = $clog2(NUM_ROWS);

    logic                    cmd_write;
    logic                    cmd_read;
    logic [ROW_W-1:0]        row_addr;
    logic [NUM_COLS-1:0]     wr_data;
    logic                    ready;
    c3sram_pkg::array_ctrl_t array_ctrl;
    logic [NUM_ROWS-1:0]     wl;
    logic [NUM_COLS-1:0]     bl_data;
    logic [NUM_COLS-1:0]     sa_out;
    logic [NUM_COLS-1:0]     rd_result;

    c3sram_apb_regs #(
        .NUM_ROWS(NUM_ROWS),
        .NUM_COLS(NUM_COLS)
    ) regs_i (
        .clk        (clk),
        .nrst       (nrst),
        .apb_req_i  (apb_req_i),
        .apb_rsp_o  (apb_rsp_o),
        .ready_i    (ready),
        .rd_result_i(rd_result),
        .cmd_write_o(cmd_write),
        .cmd_read_o (cmd_read),
        .row_addr_o (row_addr),
        .wr_data_o  (wr_data)
    );

    c3sram_row_sequencer #(
        .NUM_ROWS(NUM_ROWS),
        .NUM_COLS(NUM_COLS)
    ) seq_i (
        .clk        (clk),
        .nrst       (nrst),
        .cmd_write_i(cmd_write),
        .cmd_read_i (cmd_read),
        .row_addr_i (row_addr),
        .wr_data_i  (wr_data),
        .ready_o    (ready),
        .ctrl_o     (array_ctrl),
        .wl_o       (wl),
        .bl_data_o  (bl_data)
    );

    c3sram_array_model #(
        .NUM_ROWS(NUM_ROWS),
        .NUM_COLS(NUM_COLS)
    ) array_i (
        .clk      (clk),
        .ctrl_i   (array_ctrl),
        .wl_i     (wl),
        .bl_data_i(bl_data),
        .sa_out_o (sa_out)
    );

    c3sram_sense_latch #(
        .NUM_COLS(NUM_COLS)
    ) latch_i (
        .clk        (clk),
        .nrst       (nrst),
        .saen_i     (array_ctrl.saen),
        .sa_out_i   (sa_out),
        .rd_result_o(rd_result)
    );

endmodule

`default_nettype wire

// File: tests/tb_c3sram_top.sv
// Testbench for the C3SRAM row controller, random APB traffic from a fixed seed
// checked against a row memory model kept here.
`default_nettype none

module tb_c3sram_top;

    localparam int NUM_ROWS     = 128;
    localparam int NUM_COLS     = 32;
    localparam int ROW_W        = $clog2(NUM_ROWS);
    localparam int POLL_TIMEOUT = 50;
    localparam c3sram_pkg::apb_data_t ROW_MASK = (32'd1 << ROW_W) - 32'd1;
    localparam c3sram_pkg::apb_data_t COL_MASK =
        c3sram_pkg::apb_data_t'((64'd1 << NUM_COLS) - 64'd1);

    logic                  clk;
    logic                  nrst;
    c3sram_pkg::apb_req_t  apb_req;
    c3sram_pkg::apb_rsp_t  apb_rsp;

    // Rows written so far, anything missing reads as zero
    c3sram_pkg::apb_data_t row_model [int];
    c3sram_pkg::apb_data_t last_result;
    c3sram_pkg::apb_data_t rd_data;
    logic                  rd_err;
    int                    errors;

    c3sram_top #(
        .NUM_ROWS(NUM_ROWS),
        .NUM_COLS(NUM_COLS)
    ) dut_i (
        .clk      (clk),
        .nrst     (nrst),
        .apb_req_i(apb_req),
        .apb_rsp_o(apb_rsp)
    );

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error at %0t: %s expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // Setup then access; the access ends on the edge where the next setup is driven
    task automatic apb_xfer(input logic write, input c3sram_pkg::apb_addr_t addr,
                            input c3sram_pkg::apb_data_t wdata,
                            output c3sram_pkg::apb_data_t rdata, output logic err);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic write_reg(input c3sram_pkg::apb_addr_t addr,
                             input c3sram_pkg::apb_data_t data, input logic exp_err);
        apb_xfer(1'b1, addr, data, rd_data, rd_err);
        check("pslverr", exp_err, rd_err);
    endtask

    task automatic read_check(input c3sram_pkg::apb_addr_t addr, input string name,
                              input c3sram_pkg::apb_data_t expected);
        apb_xfer(1'b0, addr, '0, rd_data, rd_err);
        check("pslverr", 1'b0, rd_err);
        check(name, expected, rd_data);
    endtask

    task automatic wait_ready();
        int   cycles;
        logic ready;
        cycles = 0;
        ready  = 1'b0;
        while (!ready && cycles < POLL_TIMEOUT) begin
            apb_xfer(1'b0, c3sram_pkg::REG_STATUS, '0, rd_data, rd_err);
            check("pslverr", 1'b0, rd_err);
            ready  = rd_data[0];
            cycles += 2;
        end
        if (!ready) begin
            $display("STATUS never showed ready within %0d cycles", POLL_TIMEOUT);
            errors++;
            finish_run();
        end
    endtask

    function automatic c3sram_pkg::apb_data_t model_row(input int row);
        c3sram_pkg::apb_data_t value;
        value = '0;
        if (row_model.exists(row)) begin
            value = row_model[row];
        end
        return value;
    endfunction

    task automatic write_row(input int row, input c3sram_pkg::apb_data_t data);
        write_reg(c3sram_pkg::REG_ADDR, row, 1'b0);
        write_reg(c3sram_pkg::REG_WDATA, data, 1'b0);
        write_reg(c3sram_pkg::REG_CMD, 32'h1, 1'b0);
        wait_ready();
        row_model[row] = data & COL_MASK;
    endtask

    task automatic read_row(input int row);
        write_reg(c3sram_pkg::REG_ADDR, row, 1'b0);
        write_reg(c3sram_pkg::REG_CMD, 32'h2, 1'b0);
        wait_ready();
        last_result = model_row(row);
        read_check(c3sram_pkg::REG_RDATA, "prdata(RDATA)", last_result);
    endtask

    initial begin
        int                    row;
        c3sram_pkg::apb_data_t data;
        c3sram_pkg::apb_data_t last_addr;
        c3sram_pkg::apb_data_t last_wdata;
        c3sram_pkg::apb_addr_t bad_addr;
        void'($urandom(32'h3213_530a));
        errors      = 0;
        last_result = '0;
        clk         = 1'b0;
        nrst        = 1'b0;
        apb_req     = '0;
        repeat (3) @(posedge clk);
        nrst <= 1'b1;

        read_check(c3sram_pkg::REG_STATUS, "prdata(STATUS)", 32'h1);
        read_check(c3sram_pkg::REG_RDATA, "prdata(RDATA)", 32'h0);

        for (int i = 0; i < 16; i++) begin
            write_row($urandom_range(NUM_ROWS - 1), $urandom());
        end
        foreach (row_model[r]) begin
            read_row(r);
        end
        // A row nobody wrote
        row = $urandom_range(NUM_ROWS - 1);
        while (row_model.exists(row)) begin
            row = (row + 1) % NUM_ROWS;
        end
        read_row(row);

        data = $urandom();
        write_reg(c3sram_pkg::REG_ADDR, data, 1'b0);
        last_addr = data & ROW_MASK;
        read_check(c3sram_pkg::REG_ADDR, "prdata(ADDR)", last_addr);
        data = $urandom();
        write_reg(c3sram_pkg::REG_WDATA, data, 1'b0);
        last_wdata = data & COL_MASK;
        read_check(c3sram_pkg::REG_WDATA, "prdata(WDATA)", last_wdata);

        // Refused transfers, nothing may change
        write_reg(c3sram_pkg::REG_CMD, 32'h3, 1'b1);
        read_check(c3sram_pkg::REG_STATUS, "prdata(STATUS)", 32'h1);
        write_reg(c3sram_pkg::REG_CMD, 32'h0, 1'b1);
        read_check(c3sram_pkg::REG_STATUS, "prdata(STATUS)", 32'h1);
        bad_addr = 12'h014 + (c3sram_pkg::apb_addr_t'($urandom_range(1000)) << 2);
        write_reg(bad_addr, $urandom(), 1'b1);
        apb_xfer(1'b0, bad_addr, '0, rd_data, rd_err);
        check("pslverr", 1'b1, rd_err);
        write_reg(c3sram_pkg::REG_STATUS, $urandom(), 1'b1);
        write_reg(c3sram_pkg::REG_RDATA, $urandom(), 1'b1);
        read_check(c3sram_pkg::REG_RDATA, "prdata(RDATA)", last_result);
        read_check(c3sram_pkg::REG_ADDR, "prdata(ADDR)", last_addr);
        read_check(c3sram_pkg::REG_WDATA, "prdata(WDATA)", last_wdata);
        read_check(c3sram_pkg::REG_STATUS, "prdata(STATUS)", 32'h1);

        // Back-to-back commands, the second one is refused
        row  = $urandom_range(NUM_ROWS - 1);
        data = $urandom();
        write_reg(c3sram_pkg::REG_ADDR, row, 1'b0);
        write_reg(c3sram_pkg::REG_WDATA, data, 1'b0);
        write_reg(c3sram_pkg::REG_CMD, 32'h1, 1'b0);
        write_reg(c3sram_pkg::REG_CMD, 32'h2, 1'b1);
        read_check(c3sram_pkg::REG_STATUS, "prdata(STATUS)", 32'h0);
        wait_ready();
        row_model[row] = data & COL_MASK;
        read_row(row);

        for (int i = 0; i < 200; i++) begin
            row = $urandom_range(NUM_ROWS - 1);
            if ($urandom_range(1) == 1) begin
                write_row(row, $urandom());
            end else begin
                read_row(row);
            end
        end

        bus_idle();
        finish_run();
    end

endmodule

`default_nettype wire
